//--- filelist.f
+incdir+src
src/mania_pkg.sv
src/table_ram.sv
src/table_loader.sv
src/preload_arbiter.sv
src/header_scanner.sv
src/game_sequencer.sv
src/audio_pacer.sv
src/mania_core.sv
verif/mania_core_assert.sv
verif/mania_core_tb.sv

//--- src/audio_pacer.sv
`timescale 1ns/1ns
`include "mania_macros.svh"

module audio_pacer import mania_pkg::*; (
	input logic CLK,
	input logic RESET_L,
	input logic play,
	input song_sample_t song_data_in,
	input logic song_data_ready,
	output logic song_request_data,
	output song_sample_t main_audio_out,
	output logic audio_en
);

	localparam int TICK_W = $clog2(`AUDIO_PERIOD);
	localparam int DLY_W = $clog2(`PLAY_DELAY + 1);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`AUDIO_PERIOD - 1);
	localparam logic [DLY_W-1:0] DELAY_DONE = DLY_W'(`PLAY_DELAY);

	logic [TICK_W-1:0] tick_cnt;
	logic [DLY_W-1:0] delay_cnt; // ticks seen, saturates
	logic tick;

	assign tick = play && (tick_cnt == TICK_LAST);
	assign audio_en = play;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			tick_cnt <= '0;
			delay_cnt <= '0;
			song_request_data <= 1'b0;
		end else begin
			if (!play) begin
				tick_cnt <= '0;
				delay_cnt <= '0;
			end else begin
				tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
				if (tick && delay_cnt != DELAY_DONE)
					delay_cnt <= delay_cnt + 1'b1;
			end
			song_request_data <= tick && (delay_cnt == DELAY_DONE);
		end
	end

	always_ff @(posedge CLK) begin
		if (song_data_ready)
			main_audio_out <= song_data_in;
	end

endmodule

//--- src/game_sequencer.sv
`timescale 1ns/1ns

module game_sequencer import mania_pkg::*; (
	input logic CLK,
	input logic RESET_L,
	input logic beatmap_done,
	input logic timing_done,
	input logic scan_beatmap_done,
	input logic scan_timing_done,
	output core_state_t state,
	output preload_sel_t sel,
	output logic beatmap_on,
	output logic timing_on,
	output logic scan_beatmap_on,
	output logic scan_timing_on,
	output logic play
);

	core_state_t n_state;

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			state <= init;
		else
			state <= n_state;
	end

	always_comb begin
		case (state)
			init:           n_state = load_beatmap;
			load_beatmap:   n_state = w_load_beatmap;
			w_load_beatmap: n_state = beatmap_done ? load_timing : w_load_beatmap;
			load_timing:    n_state = w_load_timing;
			w_load_timing:  n_state = timing_done ? scan_beatmap : w_load_timing;
			scan_beatmap:   n_state = w_scan_beatmap;
			w_scan_beatmap: n_state = scan_beatmap_done ? scan_timing : w_scan_beatmap;
			scan_timing:    n_state = w_scan_timing;
			w_scan_timing:  n_state = scan_timing_done ? playing : w_scan_timing;
			playing:        n_state = playing;
			default:        n_state = init;
		endcase
	end

	// start states last one clock, so these are pulses
	assign beatmap_on = (state == load_beatmap);
	assign timing_on = (state == load_timing);
	assign scan_beatmap_on = (state == scan_beatmap);
	assign scan_timing_on = (state == scan_timing);
	assign play = (state == playing);

	// channel owner during each load
	assign sel = (state == load_beatmap || state == w_load_beatmap) ? sel_beatmap :
		(state == load_timing || state == w_load_timing) ? sel_timing : sel_none;

endmodule

//--- src/header_scanner.sv
`timescale 1ns/1ns
`include "mania_macros.svh"

module header_scanner import mania_pkg::*; (
	input logic CLK,
	input logic RESET_L,
	input logic scan_beatmap_on,
	input logic scan_timing_on,
	input beatmap_word_t beatmap_rdata,
	input timing_word_t timing_rdata,
	output beatmap_addr_t beatmap_raddr,
	output timing_addr_t timing_raddr,
	output chart_table_t chart_base,
	output chart_table_t chart_size,
	output timing_addr_t timing_size,
	output song_len_t song_length,
	output logic scan_beatmap_done,
	output logic scan_timing_done
);

	localparam int PAT_W = $clog2(`SCAN_PAT);
	localparam logic [PAT_W-1:0] PAT_LAST = PAT_W'(`SCAN_PAT - 1);
	localparam logic [1:0] CHART_LAST = 2'(`CHART_COUNT - 1);
	localparam logic [1:0] TIMING_LAST = 2'(`TIMING_BASE - 1);

	logic bm_run;
	logic tm_run;
	logic [PAT_W-1:0] pat;
	logic [1:0] idx; // chart number, or timing header entry
	beatmap_addr_t next_addr;

	// size word of chart k sits right behind chart k-1
	assign next_addr = (idx == 2'd0) ? '0 :
		beatmap_addr_t'(chart_base[idx - 2'd1] + chart_size[idx - 2'd1]);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			bm_run <= 1'b0;
			tm_run <= 1'b0;
			pat <= '0;
			idx <= '0;
			beatmap_raddr <= '0;
			timing_raddr <= '0;
			chart_base <= '0;
			chart_size <= '0;
			timing_size <= '0;
			song_length <= '0;
			scan_beatmap_done <= 1'b0;
			scan_timing_done <= 1'b0;
		end else begin
			scan_beatmap_done <= 1'b0;
			scan_timing_done <= 1'b0;
			if (scan_beatmap_on) begin
				bm_run <= 1'b1;
				pat <= '0;
				idx <= '0;
			end else if (scan_timing_on) begin
				tm_run <= 1'b1;
				pat <= '0;
				idx <= '0;
			end else if (bm_run || tm_run) begin
				pat <= (pat == PAT_LAST) ? '0 : pat + 1'b1;
				if (pat == '0) begin
					if (bm_run)
						beatmap_raddr <= next_addr;
					else
						timing_raddr <= timing_addr_t'(idx);
				end else if (pat == PAT_LAST) begin
					if (bm_run) begin
						chart_size[idx] <= beatmap_rdata[$bits(beatmap_addr_t)-1:0];
						chart_base[idx] <= beatmap_raddr + 1'b1; // data follows its size word
						if (idx == CHART_LAST) begin
							bm_run <= 1'b0;
							scan_beatmap_done <= 1'b1;
						end
					end else begin
						if (idx == 2'd0)
							timing_size <= timing_rdata[$bits(timing_addr_t)-1:0];
						else
							song_length <= timing_rdata[$bits(song_len_t)-1:0];
						if (idx == TIMING_LAST) begin
							tm_run <= 1'b0;
							scan_timing_done <= 1'b1;
						end
					end
					idx <= idx + 1'b1;
				end
			end
		end
	end

endmodule

//--- src/mania_core.sv
`timescale 1ns/1ns
`include "mania_macros.svh"

module mania_core import mania_pkg::*; (
	input logic CLK,
	input logic RESET_L,
	input logic [7:0] song_selection,
	output logic [7:0] pre_init_index,
	output logic [7:0] pre_init_aux_info,
	output logic pre_request_data,
	output logic pre_restart,
	input pre_byte_t pre_data_in,
	input logic pre_data_ready,
	input logic pre_transmit_finished,
	input song_sample_t song_data_in,
	input logic song_data_ready,
	output logic song_request_data,
	output song_sample_t main_audio_out,
	output logic audio_en,
	output chart_table_t chart_base,
	output chart_table_t chart_size,
	output timing_addr_t timing_size,
	output song_len_t song_length,
	output core_state_t debug_state
);

	preload_sel_t sel;
	logic beatmap_on, timing_on, scan_beatmap_on, scan_timing_on, play;
	logic beatmap_done, timing_done, scan_beatmap_done, scan_timing_done;

	logic [7:0] bm_init_index, bm_init_aux_info, tm_init_index, tm_init_aux_info;
	logic bm_request_data, bm_restart, tm_request_data, tm_restart;
	logic bm_data_ready, bm_transmit_finished, tm_data_ready, tm_transmit_finished;
	pre_byte_t ld_data;

	logic bm_we, tm_we;
	beatmap_addr_t bm_waddr, bm_raddr;
	timing_addr_t tm_waddr, tm_raddr;
	beatmap_word_t bm_wdata, bm_rdata;
	timing_word_t tm_wdata, tm_rdata;

	game_sequencer u_seq (
		.CLK(CLK), .RESET_L(RESET_L),
		.beatmap_done(beatmap_done), .timing_done(timing_done),
		.scan_beatmap_done(scan_beatmap_done), .scan_timing_done(scan_timing_done),
		.state(debug_state), .sel(sel),
		.beatmap_on(beatmap_on), .timing_on(timing_on),
		.scan_beatmap_on(scan_beatmap_on), .scan_timing_on(scan_timing_on),
		.play(play)
	);

	table_loader #(.word_t(beatmap_word_t), .ADDR_W($bits(beatmap_addr_t)),
		.AUX(`AUX_BEATMAP)) u_bm_loader (
		.CLK(CLK), .RESET_L(RESET_L), .start(beatmap_on), .song_selection(song_selection),
		.data_ready(bm_data_ready), .data_in(ld_data),
		.transmit_finished(bm_transmit_finished),
		.init_index(bm_init_index), .init_aux_info(bm_init_aux_info),
		.request_data(bm_request_data), .restart(bm_restart),
		.we(bm_we), .waddr(bm_waddr), .wdata(bm_wdata), .done(beatmap_done)
	);

	table_loader #(.word_t(timing_word_t), .ADDR_W($bits(timing_addr_t)),
		.AUX(`AUX_TIMING)) u_tm_loader (
		.CLK(CLK), .RESET_L(RESET_L), .start(timing_on), .song_selection(song_selection),
		.data_ready(tm_data_ready), .data_in(ld_data),
		.transmit_finished(tm_transmit_finished),
		.init_index(tm_init_index), .init_aux_info(tm_init_aux_info),
		.request_data(tm_request_data), .restart(tm_restart),
		.we(tm_we), .waddr(tm_waddr), .wdata(tm_wdata), .done(timing_done)
	);

	preload_arbiter u_arb (
		.sel(sel),
		.bm_init_index(bm_init_index), .bm_init_aux_info(bm_init_aux_info),
		.bm_request_data(bm_request_data), .bm_restart(bm_restart),
		.tm_init_index(tm_init_index), .tm_init_aux_info(tm_init_aux_info),
		.tm_request_data(tm_request_data), .tm_restart(tm_restart),
		.pre_data_ready(pre_data_ready), .pre_data_in(pre_data_in),
		.pre_transmit_finished(pre_transmit_finished),
		.pre_init_index(pre_init_index), .pre_init_aux_info(pre_init_aux_info),
		.pre_request_data(pre_request_data), .pre_restart(pre_restart),
		.ld_data(ld_data),
		.bm_data_ready(bm_data_ready), .bm_transmit_finished(bm_transmit_finished),
		.tm_data_ready(tm_data_ready), .tm_transmit_finished(tm_transmit_finished)
	);

	table_ram #(.word_t(beatmap_word_t), .ADDR_W($bits(beatmap_addr_t))) u_bm_ram (
		.CLK(CLK), .we(bm_we), .waddr(bm_waddr), .wdata(bm_wdata),
		.raddr(bm_raddr), .rdata(bm_rdata)
	);

	table_ram #(.word_t(timing_word_t), .ADDR_W($bits(timing_addr_t))) u_tm_ram (
		.CLK(CLK), .we(tm_we), .waddr(tm_waddr), .wdata(tm_wdata),
		.raddr(tm_raddr), .rdata(tm_rdata)
	);

	header_scanner u_scan (
		.CLK(CLK), .RESET_L(RESET_L),
		.scan_beatmap_on(scan_beatmap_on), .scan_timing_on(scan_timing_on),
		.beatmap_rdata(bm_rdata), .timing_rdata(tm_rdata),
		.beatmap_raddr(bm_raddr), .timing_raddr(tm_raddr),
		.chart_base(chart_base), .chart_size(chart_size),
		.timing_size(timing_size), .song_length(song_length),
		.scan_beatmap_done(scan_beatmap_done), .scan_timing_done(scan_timing_done)
	);

	audio_pacer u_audio (
		.CLK(CLK), .RESET_L(RESET_L), .play(play),
		.song_data_in(song_data_in), .song_data_ready(song_data_ready),
		.song_request_data(song_request_data), .main_audio_out(main_audio_out),
		.audio_en(audio_en)
	);

endmodule

//--- src/mania_macros.svh
`ifndef MANIA_MACROS_SVH
`define MANIA_MACROS_SVH

// clocks per audio tick
`define AUDIO_PERIOD 16

// audio ticks before the first song request
`define PLAY_DELAY 4

`define CHART_COUNT 4

// aux info per preload region
`define AUX_BEATMAP 8'h00
`define AUX_TIMING 8'h03

// first timing entry after the header
`define TIMING_BASE 2

// clocks per header read
`define SCAN_PAT 4

`endif

//--- src/mania_pkg.sv
`include "mania_macros.svh"

package mania_pkg;

	// boot and play states, BCD style
	typedef enum logic [15:0] {
		init           = 16'h0000,
		load_beatmap   = 16'h0001,
		w_load_beatmap = 16'h0002,
		load_timing    = 16'h0003,
		w_load_timing  = 16'h0004,
		scan_beatmap   = 16'h0005,
		w_scan_beatmap = 16'h0006,
		scan_timing    = 16'h0007,
		w_scan_timing  = 16'h0008,
		playing        = 16'h0100
	} core_state_t;

	typedef logic [23:0] beatmap_word_t;
	typedef logic [31:0] timing_word_t;
	typedef logic [12:0] beatmap_addr_t;
	typedef logic [11:0] timing_addr_t;
	typedef beatmap_addr_t [`CHART_COUNT-1:0] chart_table_t; // indexed by chart
	typedef logic [19:0] song_len_t;
	typedef logic [7:0] pre_byte_t;
	typedef logic [7:0] song_sample_t;

	typedef enum logic [1:0] {sel_none, sel_beatmap, sel_timing} preload_sel_t;

endpackage

//--- src/preload_arbiter.sv
`timescale 1ns/1ns

module preload_arbiter import mania_pkg::*; (
	input preload_sel_t sel,
	input logic [7:0] bm_init_index,
	input logic [7:0] bm_init_aux_info,
	input logic bm_request_data,
	input logic bm_restart,
	input logic [7:0] tm_init_index,
	input logic [7:0] tm_init_aux_info,
	input logic tm_request_data,
	input logic tm_restart,
	input logic pre_data_ready,
	input pre_byte_t pre_data_in,
	input logic pre_transmit_finished,
	output logic [7:0] pre_init_index,
	output logic [7:0] pre_init_aux_info,
	output logic pre_request_data,
	output logic pre_restart,
	output pre_byte_t ld_data,
	output logic bm_data_ready,
	output logic bm_transmit_finished,
	output logic tm_data_ready,
	output logic tm_transmit_finished
);

	always_comb begin
		pre_init_index = '0;
		pre_init_aux_info = '0;
		pre_request_data = 1'b0;
		pre_restart = 1'b0;
		case (sel)
			sel_beatmap: begin
				pre_init_index = bm_init_index;
				pre_init_aux_info = bm_init_aux_info;
				pre_request_data = bm_request_data;
				pre_restart = bm_restart;
			end
			sel_timing: begin
				pre_init_index = tm_init_index;
				pre_init_aux_info = tm_init_aux_info;
				pre_request_data = tm_request_data;
				pre_restart = tm_restart;
			end
			default: ;
		endcase
	end

	// returns go to the owner only
	assign bm_data_ready = (sel == sel_beatmap) && pre_data_ready;
	assign bm_transmit_finished = (sel == sel_beatmap) && pre_transmit_finished;
	assign tm_data_ready = (sel == sel_timing) && pre_data_ready;
	assign tm_transmit_finished = (sel == sel_timing) && pre_transmit_finished;

	// shared byte, ready alone qualifies it
	assign ld_data = pre_data_in;

endmodule

//--- src/table_loader.sv
`timescale 1ns/1ns

module table_loader import mania_pkg::*; #(
	parameter type word_t = logic [23:0],
	parameter int ADDR_W = 13,
	parameter logic [7:0] AUX = 8'h00
) (
	input logic CLK,
	input logic RESET_L,
	input logic start,
	input logic [7:0] song_selection,
	input logic data_ready,
	input pre_byte_t data_in,
	input logic transmit_finished,
	output logic [7:0] init_index,
	output logic [7:0] init_aux_info,
	output logic request_data,
	output logic restart,
	output logic we,
	output logic [ADDR_W-1:0] waddr,
	output word_t wdata,
	output logic done
);

	localparam int BYTES = $bits(word_t) / 8;
	localparam int CNT_W = (BYTES > 1) ? $clog2(BYTES) : 1;
	localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BYTES - 1);

	typedef enum logic [1:0] {ph_idle, ph_restart, ph_settle, ph_run} phase_t;

	phase_t phase;
	logic pending; // request out, byte not back yet
	logic [CNT_W-1:0] byte_cnt;
	word_t acc;
	logic take;

	assign init_index = song_selection;
	assign init_aux_info = AUX;
	assign wdata = acc;
	assign take = (phase == ph_run) && pending && data_ready;

	// lsb first
	always_ff @(posedge CLK) begin
		if (take)
			acc[byte_cnt*8 +: 8] <= data_in;
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			phase <= ph_idle;
			pending <= 1'b0;
			byte_cnt <= '0;
			request_data <= 1'b0;
			restart <= 1'b0;
			we <= 1'b0;
			waddr <= '0;
			done <= 1'b0;
		end else begin
			request_data <= 1'b0;
			restart <= 1'b0;
			we <= 1'b0;
			done <= 1'b0;
			if (we)
				waddr <= waddr + 1'b1;
			case (phase)
				ph_idle: begin
					if (start) begin
						restart <= 1'b1;
						pending <= 1'b0;
						byte_cnt <= '0;
						waddr <= '0;
						phase <= ph_restart;
					end
				end
				ph_restart: phase <= ph_settle;
				// finished of the old region is still visible here
				ph_settle: phase <= ph_run;
				ph_run: begin
					if (take) begin
						pending <= 1'b0;
						if (byte_cnt == LAST_BYTE) begin
							byte_cnt <= '0;
							we <= 1'b1; // word complete
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
					end else if (!pending) begin
						if (transmit_finished) begin
							done <= 1'b1;
							phase <= ph_idle;
						end else begin
							request_data <= 1'b1;
							pending <= 1'b1;
						end
					end
				end
				default: phase <= ph_idle;
			endcase
		end
	end

endmodule

//--- src/table_ram.sv
`timescale 1ns/1ns

module table_ram #(
	parameter type word_t = logic [7:0],
	parameter int ADDR_W = 8
) (
	input logic CLK,
	input logic we,
	input logic [ADDR_W-1:0] waddr,
	input word_t wdata,
	input logic [ADDR_W-1:0] raddr,
	output word_t rdata
);

	word_t mem [0:(1 << ADDR_W) - 1];

	always_ff @(posedge CLK) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // one cycle read latency
	end

endmodule

//--- verif/mania_core_assert.sv
`timescale 1ns/1ns

module mania_core_assert import mania_pkg::*; (
	input logic CLK,
	input logic RESET_L,
	input logic pre_request_data,
	input logic pre_data_ready,
	input logic pre_restart,
	input logic audio_en,
	input core_state_t debug_state
);

	int fail_cnt = 0; // failed assertions so far
	logic open_req; // request out, ready not seen yet

	always_ff @(posedge CLK) begin
		if (!RESET_L)
			open_req <= 1'b0;
		else if (pre_data_ready)
			open_req <= 1'b0;
		else if (pre_request_data)
			open_req <= 1'b1;
	end

	single_request: assert property (@(posedge CLK) disable iff (!RESET_L)
		pre_request_data |-> !open_req)
		else begin
			fail_cnt++;
			$error("preload request issued before the previous byte arrived");
		end

	restart_pulse: assert property (@(posedge CLK) disable iff (!RESET_L)
		pre_restart |=> !pre_restart)
		else begin
			fail_cnt++;
			$error("preload restart held longer than one clock");
		end

	audio_in_play: assert property (@(posedge CLK) disable iff (!RESET_L)
		audio_en |-> debug_state == playing)
		else begin
			fail_cnt++;
			$error("audio enabled outside the playing state");
		end

endmodule

//--- verif/mania_core_tb.sv
`timescale 1ns/1ns
`include "mania_macros.svh"

module mania_core_tb import mania_pkg::*; ();

	localparam int TRACE_WORDS = 256;
	localparam int BOOT_TIMEOUT = 4000;
	localparam int REQ_TIMEOUT = 400;

	logic CLK;
	logic RESET_L;
	logic [7:0] song_selection;
	logic [7:0] pre_init_index;
	logic [7:0] pre_init_aux_info;
	logic pre_request_data;
	logic pre_restart;
	pre_byte_t pre_data_in;
	logic pre_data_ready;
	logic pre_transmit_finished;
	song_sample_t song_data_in;
	logic song_data_ready;
	logic song_request_data;
	song_sample_t main_audio_out;
	logic audio_en;
	chart_table_t chart_base;
	chart_table_t chart_size;
	timing_addr_t timing_size;
	song_len_t song_length;
	core_state_t debug_state;

	logic [31:0] trace [0:TRACE_WORDS-1];
	int bm_start, bm_len, tm_start, tm_len, exp_pos, smp_start, smp_cnt;
	int mismatch_cnt = 0;
	int other_cnt = 0;
	int cyc = 0;
	int restart_cnt = 0;
	int sd_ptr = 0; // next byte of the open region
	int sd_left = 0;
	int sd_wait = 0; // clocks until the ready pulse
	logic [7:0] lfsr = 8'd85;

	mania_core dut_i (.*);

	bind mania_core mania_core_assert assert_i (
		.CLK(CLK), .RESET_L(RESET_L),
		.pre_request_data(pre_request_data), .pre_data_ready(pre_data_ready),
		.pre_restart(pre_restart), .audio_en(audio_en), .debug_state(debug_state)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) cyc <= cyc + 1;

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// two lfsr bits, 1 to 4 clocks
	task automatic draw_delay(output int d);
		lfsr = lfsr_next(lfsr);
		d = 2 * lfsr[0];
		lfsr = lfsr_next(lfsr);
		d = d + lfsr[0] + 1;
	endtask

	task automatic check_addr(input beatmap_addr_t got, input beatmap_addr_t exp, input string name);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_timing(input timing_word_t got, input timing_word_t exp, input string name);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_sample(input song_sample_t got, input song_sample_t exp, input string name);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_byte(input pre_byte_t got, input pre_byte_t exp, input string name);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	// SD preload model
	always @(posedge CLK) begin
		int delay;
		pre_data_ready <= 1'b0;
		if (!RESET_L) begin
			sd_wait <= 0;
		end else if (pre_restart) begin
			check_byte(pre_init_index, song_selection, "pre_init_index");
			if (restart_cnt == 0) begin
				check_byte(pre_init_aux_info, `AUX_BEATMAP, "pre_init_aux_info");
				sd_ptr <= bm_start;
				sd_left <= bm_len;
				pre_transmit_finished <= (bm_len == 0);
			end else if (restart_cnt == 1) begin
				check_byte(pre_init_aux_info, `AUX_TIMING, "pre_init_aux_info");
				sd_ptr <= tm_start;
				sd_left <= tm_len;
				pre_transmit_finished <= (tm_len == 0);
			end else begin
				other_cnt++;
				$display("unexpected preload restart number %0d", restart_cnt + 1);
			end
			restart_cnt <= restart_cnt + 1;
			sd_wait <= 0;
		end else if (sd_wait == 1) begin
			pre_data_ready <= 1'b1;
			pre_data_in <= trace[sd_ptr][7:0];
			sd_ptr <= sd_ptr + 1;
			sd_left <= sd_left - 1;
			if (sd_left == 1)
				pre_transmit_finished <= 1'b1; // region drained
			sd_wait <= 0;
		end else if (sd_wait > 1) begin
			sd_wait <= sd_wait - 1;
		end else if (pre_request_data) begin
			if (sd_left == 0) begin
				other_cnt++;
				$display("preload request with no bytes left in the region");
			end else begin
				draw_delay(delay);
				sd_wait <= delay;
			end
		end
	end

	// answer each song request with the next trace sample
	task automatic serve_songs(input int play_cyc);
		int i;
		int wait_cnt;
		int last_cyc;
		int exp_gap;
		bit lost;
		last_cyc = play_cyc;
		lost = 1'b0;
		for (i = 0; i < smp_cnt && !lost; i++) begin
			wait_cnt = 0;
			while (!song_request_data && wait_cnt < REQ_TIMEOUT) begin
				@(negedge CLK);
				wait_cnt++;
			end
			if (!song_request_data) begin
				other_cnt++;
				$display("song request %0d did not arrive within %0d clocks", i, REQ_TIMEOUT);
				lost = 1'b1;
			end else begin
				exp_gap = (i == 0) ? (`PLAY_DELAY + 1) * `AUDIO_PERIOD : `AUDIO_PERIOD;
				if (cyc - last_cyc != exp_gap) begin
					other_cnt++;
					$display("song request %0d came %0d clocks after the previous event, expected %0d",
						i, cyc - last_cyc, exp_gap);
				end
				last_cyc = cyc;
				@(posedge CLK);
				song_data_in <= trace[smp_start + i][7:0];
				song_data_ready <= 1'b1;
				@(posedge CLK);
				song_data_ready <= 1'b0;
				@(negedge CLK);
				check_sample(main_audio_out, trace[smp_start + i][7:0], "main_audio_out");
			end
		end
	endtask

	initial begin
		int wait_cnt;
		int k;
		int play_cyc;
		int assert_fails;
		$readmemh("verif/mania_trace.txt", trace);
		bm_len = trace[1];
		bm_start = 2;
		tm_len = trace[bm_start + bm_len];
		tm_start = bm_start + bm_len + 1;
		exp_pos = tm_start + tm_len;
		smp_cnt = trace[exp_pos + 10];
		smp_start = exp_pos + 11;

		RESET_L = 1'b0;
		song_selection = trace[0][7:0];
		pre_data_in = '0;
		pre_data_ready = 1'b0;
		pre_transmit_finished = 1'b0;
		song_data_in = '0;
		song_data_ready = 1'b0;

		repeat (10) @(posedge CLK);
		RESET_L <= 1'b1;
		@(negedge CLK);
		check_byte(pre_byte_t'(audio_en), 8'h00, "audio_en");
		check_byte(pre_byte_t'(pre_restart), 8'h00, "pre_restart");
		check_byte(pre_byte_t'(pre_request_data), 8'h00, "pre_request_data");

		wait_cnt = 0;
		while (debug_state != playing && wait_cnt < BOOT_TIMEOUT) begin
			@(negedge CLK);
			wait_cnt++;
		end
		if (debug_state != playing) begin
			other_cnt++;
			$display("boot did not reach the playing state within %0d clocks", BOOT_TIMEOUT);
		end else begin
			play_cyc = cyc;
			check_byte(pre_byte_t'(audio_en), 8'h01, "audio_en");
			if (restart_cnt != 2) begin
				other_cnt++;
				$display("saw %0d preload restarts during boot instead of 2", restart_cnt);
			end
			for (k = 0; k < `CHART_COUNT; k++) begin
				check_addr(chart_size[k], beatmap_addr_t'(trace[exp_pos + k]),
					$sformatf("chart_size[%0d]", k));
				check_addr(chart_base[k], beatmap_addr_t'(trace[exp_pos + 4 + k]),
					$sformatf("chart_base[%0d]", k));
			end
			check_timing(timing_word_t'(timing_size), trace[exp_pos + 8], "timing_size");
			check_timing(timing_word_t'(song_length), trace[exp_pos + 9], "song_length");
			serve_songs(play_cyc);
		end

		assert_fails = dut_i.assert_i.fail_cnt;
		$display("mismatches %0d, other errors %0d, assertion failures %0d",
			mismatch_cnt, other_cnt, assert_fails);
		if (mismatch_cnt == 0 && other_cnt == 0 && assert_fails == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verif/mania_trace.txt
// hex words: song selection, then per region a byte count and its bytes, lsb first per word
// then chart sizes 0-3, chart bases 0-3, timing size, song length, sample count, samples
2a          // song selection
1e          // beatmap bytes, 24-bit words
02 00 00    // chart 0 size
11 22 33
44 55 66
01 00 00    // chart 1 size
77 88 99
01 00 00    // chart 2 size
aa bb cc
02 00 00    // chart 3 size
dd ee ff
10 20 30
14          // timing bytes, 32-bit words
03 00 00 00 // timing size
45 23 01 00 // song length
00 01 00 00
80 02 00 00
00 05 00 00
2 1 1 2     // expected chart sizes
1 4 6 8     // expected chart bases
003 12345   // expected timing size and song length
4           // song samples
5a a5 3c c3
